// ==== rvCore.f ====
src/rvCorePkg.sv
src/instrDecoder.sv
src/regFile.sv
src/intAlu.sv
src/loadStoreUnit.sv
src/coreControl.sv
src/rvCore.sv
bench/tbMemory.sv
bench/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rvCore

sources:
  - src/rvCorePkg.sv
  - src/instrDecoder.sv
  - src/regFile.sv
  - src/intAlu.sv
  - src/loadStoreUnit.sv
  - src/coreControl.sv
  - src/rvCore.sv
  - target: test
    files:
      - bench/tbMemory.sv
      - bench/rvCoreTb.sv

// ==== bench/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb;

   localparam int TimeoutCycles = 20000;

   logic                       clk;
   logic                       reset;
   rvCorePkg::memRequest       memReq;
   logic [rvCorePkg::XLen-1:0] memRdata;
   logic                       memRbusy;
   logic                       memWbusy;
   int                         storeIdx;     // Next entry of the expected log
   logic                       fetchSeen;
   logic                       doneSeen;
   logic                       isWrite;
   logic                       isDone;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   rvCore dut_i (.clk, .reset, .memReq, .memRdata, .memRbusy, .memWbusy);

   // Memory drives rdata and both busy levels
   tbMemory mem_i (.clk, .req(memReq), .rdata(memRdata), .rbusy(memRbusy), .wbusy(memWbusy));

   function automatic logic [31:0] laneMask(logic [31:0] d, logic [3:0] m);
      return d & {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   task automatic abortRun();
      $display("TEST FAIL");
      $fatal(1, "Stopping at first error");
   endtask

   assign isWrite = memReq.wmask != 4'b0;
   assign isDone  = isWrite && memReq.addr == mem_i.DoneAddr;

   always @(posedge clk) begin
      if (!reset) begin
         storeIdx  <= 0;
         fetchSeen <= 1'b0;
         doneSeen  <= 1'b0;
      end else begin
         if (memReq.rstrb) fetchSeen <= 1'b1;
         if (isDone) doneSeen <= 1'b1;
         else if (isWrite) storeIdx <= storeIdx + 1;
      end
   end

   resetQuiet: assert property (@(posedge clk) !reset |-> memReq.wmask == 4'b0)
      else begin
         $display("** Error resetQuiet: expected wmask 0000, actual %b", $sampled(memReq.wmask));
         abortRun();
      end

   firstFetch: assert property (@(posedge clk) disable iff (!reset)
      memReq.rstrb && !fetchSeen |-> memReq.addr == rvCorePkg::ResetAddr)
      else begin
         $display("** Error firstFetch: expected addr %h, actual %h",
                  rvCorePkg::ResetAddr, $sampled(memReq.addr));
         abortRun();
      end

   noExtraStore: assert property (@(posedge clk) disable iff (!reset)
      isWrite && !isDone |-> storeIdx < mem_i.expCount)
      else begin
         $display("Unexpected store beyond the end of the expected sequence");
         abortRun();
      end

   // Address, mask and the masked lanes of each store in program order
   storeMatch: assert property (@(posedge clk) disable iff (!reset)
      isWrite && !isDone && storeIdx < mem_i.expCount |->
         memReq.addr == mem_i.expAddr[storeIdx] && memReq.wmask == mem_i.expMask[storeIdx]
         && laneMask(memReq.wdata, memReq.wmask)
            == laneMask(mem_i.expData[storeIdx], mem_i.expMask[storeIdx]))
      else begin
         $display("** Error storeMatch #%0d (addr data mask): expected %h %h %b, actual %h %h %b",
                  $sampled(storeIdx), mem_i.expAddr[$sampled(storeIdx)],
                  laneMask(mem_i.expData[$sampled(storeIdx)], mem_i.expMask[$sampled(storeIdx)]),
                  mem_i.expMask[$sampled(storeIdx)], $sampled(memReq.addr),
                  laneMask($sampled(memReq.wdata), $sampled(memReq.wmask)),
                  $sampled(memReq.wmask));
         abortRun();
      end

   allStores: assert property (@(posedge clk) disable iff (!reset)
      isDone |-> storeIdx == mem_i.expCount)
      else begin
         $display("** Error allStores: expected %0d stores, actual %0d",
                  mem_i.expCount, $sampled(storeIdx));
         abortRun();
      end

   initial begin
      int cycles;
      reset = 1'b0;
      void'($urandom(32'hc83a_3462));
      repeat (4) @(posedge clk);
      reset <= 1'b1;
      for (cycles = 0; cycles < TimeoutCycles && !doneSeen; cycles++) begin
         @(posedge clk);
      end
      if (doneSeen) begin
         $display("TEST PASS");
         $finish;
      end else begin
         $display("TEST FAIL");
         $fatal(1, "Timed out waiting for the write to the done address");
      end
   end

endmodule

// ==== bench/tbMemory.sv ====
`timescale 1ns/1ps

module tbMemory (
   input  logic                       clk,
   input  rvCorePkg::memRequest       req,
   output logic [rvCorePkg::XLen-1:0] rdata,
   output logic                       rbusy,
   output logic                       wbusy
);

   localparam int Words = 2048;                    // 8 KiB, index is addr[12:2]
   localparam logic [31:0] DataBase = 32'h0000_1000;
   localparam logic [31:0] DoneAddr = 32'h0000_17FC;
   localparam logic [31:0] ValA = 32'h8765_4321;   // x2
   localparam logic [31:0] ValB = 32'h0000_0005;   // x3
   localparam logic [31:0] ValC = 32'hFFFF_FFF9;   // x4 = -7
   localparam logic [31:0] Poison = 32'hFFFF_FFFF; // x9

   logic [31:0] mem [Words];
   logic [31:0] expAddr [64];                      // Expected store log, in program order
   logic [31:0] expData [64];
   logic [3:0]  expMask [64];
   int          expCount;
   int          pcw;                               // Word index of next instruction
   int          off;                               // Next free result slot
   int unsigned rCnt;
   int unsigned wCnt;

   function automatic logic [31:0] encR(logic [2:0] f3, logic alt, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rvCorePkg::OpAluReg, 2'b11};
   endfunction

   function automatic logic [31:0] encI(rvCorePkg::opcodeClass op, logic [2:0] f3,
                                        logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] encS(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [11:0] imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], rvCorePkg::OpStore, 2'b11};
   endfunction

   function automatic logic [31:0] encB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvCorePkg::OpBranch, 2'b11};
   endfunction

   function automatic logic [31:0] encU(rvCorePkg::opcodeClass op, logic [4:0] rd,
                                        logic [19:0] imm);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] encJ(logic [4:0] rd, logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvCorePkg::OpJal, 2'b11};
   endfunction

   function automatic logic [31:0] sext12(logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   // Branch rules by funct3
   function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic emit(logic [31:0] w);
      mem[pcw] = w;
      pcw++;
   endtask

   task automatic logStore(logic [31:0] addr, logic [31:0] data, logic [3:0] mask);
      expAddr[expCount] = addr;
      expData[expCount] = data;
      expMask[expCount] = mask;
      expCount++;
   endtask

   task automatic storeWord(logic [4:0] rs, logic [31:0] exp);
      emit(encS(3'd2, 5'd1, rs, 12'(off)));
      logStore(DataBase + 32'(off), exp, 4'hF);
      off += 4;
   endtask

   task automatic aluCheck(logic [31:0] w, logic [31:0] exp);
      emit(w);                                     // Result always lands in x5
      storeWord(5'd5, exp);
   endtask

   task automatic loadCheck(logic [2:0] f3, int offs, logic [31:0] exp);
      emit(encI(rvCorePkg::OpLoad, f3, 5'd8, 5'd1, 12'(12'h408 + offs)));
      storeWord(5'd8, exp);
   endtask

   task automatic poisonStore();
      emit(encS(3'd2, 5'd1, 5'd9, 12'h7F8));
   endtask

   task automatic branchCheck(logic [2:0] f3, logic [4:0] rs1, logic [31:0] a,
                              logic [4:0] rs2, logic [31:0] b);
      emit(encB(f3, rs1, rs2, 13'd8));             // Taken skips the poison store
      poisonStore();
      if (!branchTaken(f3, a, b)) logStore(DataBase + 32'h7F8, Poison, 4'hF);
   endtask

   initial begin
      logic [31:0] jp;
      for (int i = 0; i < Words; i++) mem[i] = {i[15:0] ^ 16'h5A5A, ~i[15:0]};
      rdata = '0;
      rbusy = 1'b0;
      wbusy = 1'b0;
      rCnt = 0;
      wCnt = 0;
      pcw = 0;
      off = 0;
      expCount = 0;
      emit(encU(rvCorePkg::OpLui, 5'd1, 20'h00001));                 // x1 = data base
      emit(encU(rvCorePkg::OpLui, 5'd2, 20'h87654));
      emit(encI(rvCorePkg::OpAluImm, 3'd0, 5'd2, 5'd2, 12'h321));
      emit(encI(rvCorePkg::OpAluImm, 3'd0, 5'd3, 5'd0, 12'd5));
      emit(encI(rvCorePkg::OpAluImm, 3'd0, 5'd4, 5'd0, 12'hFF9));
      emit(encI(rvCorePkg::OpAluImm, 3'd0, 5'd9, 5'd0, 12'hFFF));
      // Register forms
      aluCheck(encR(3'd0, 1'b0, 5'd5, 5'd2, 5'd3), ValA + ValB);
      aluCheck(encR(3'd0, 1'b1, 5'd5, 5'd2, 5'd4), ValA - ValC);
      aluCheck(encR(3'd1, 1'b0, 5'd5, 5'd2, 5'd3), ValA << ValB[4:0]);
      aluCheck(encR(3'd5, 1'b0, 5'd5, 5'd2, 5'd3), ValA >> ValB[4:0]);
      aluCheck(encR(3'd5, 1'b1, 5'd5, 5'd2, 5'd3), 32'($signed(ValA) >>> ValB[4:0]));
      aluCheck(encR(3'd2, 1'b0, 5'd5, 5'd2, 5'd3), {31'b0, $signed(ValA) < $signed(ValB)});
      aluCheck(encR(3'd2, 1'b0, 5'd5, 5'd3, 5'd4), {31'b0, $signed(ValB) < $signed(ValC)});
      aluCheck(encR(3'd3, 1'b0, 5'd5, 5'd2, 5'd3), {31'b0, ValA < ValB});
      aluCheck(encR(3'd3, 1'b0, 5'd5, 5'd3, 5'd4), {31'b0, ValB < ValC});
      aluCheck(encR(3'd4, 1'b0, 5'd5, 5'd2, 5'd4), ValA ^ ValC);
      aluCheck(encR(3'd6, 1'b0, 5'd5, 5'd2, 5'd4), ValA | ValC);
      aluCheck(encR(3'd7, 1'b0, 5'd5, 5'd2, 5'd4), ValA & ValC);
      // Immediate forms
      aluCheck(encI(rvCorePkg::OpAluImm, 3'd0, 5'd5, 5'd2, 12'hFF9), ValA + sext12(12'hFF9));
      aluCheck(encI(rvCorePkg::OpAluImm, 3'd2, 5'd5, 5'd4, 12'hFFD),
               {31'b0, $signed(ValC) < $signed(sext12(12'hFFD))});
      aluCheck(encI(rvCorePkg::OpAluImm, 3'd3, 5'd5, 5'd3, 12'hFFF),
               {31'b0, ValB < sext12(12'hFFF)});
      aluCheck(encI(rvCorePkg::OpAluImm, 3'd4, 5'd5, 5'd2, 12'h7F0), ValA ^ sext12(12'h7F0));
      aluCheck(encI(rvCorePkg::OpAluImm, 3'd6, 5'd5, 5'd4, 12'h123), ValC | sext12(12'h123));
      aluCheck(encI(rvCorePkg::OpAluImm, 3'd7, 5'd5, 5'd2, 12'hFF0), ValA & sext12(12'hFF0));
      aluCheck(encI(rvCorePkg::OpAluImm, 3'd1, 5'd5, 5'd2, 12'h007), ValA << 7);
      aluCheck(encI(rvCorePkg::OpAluImm, 3'd5, 5'd5, 5'd2, 12'h009), ValA >> 9);
      aluCheck(encI(rvCorePkg::OpAluImm, 3'd5, 5'd5, 5'd2, 12'h409), 32'($signed(ValA) >>> 9));
      // Byte and halfword stores at every offset
      for (int k = 0; k < 4; k++) begin
         emit(encS(3'd0, 5'd1, 5'd2, 12'(12'h400 + k)));
         logStore(DataBase + 32'h400 + 32'(k), {4{ValA[7:0]}}, 4'b0001 << k);
      end
      emit(encS(3'd1, 5'd1, 5'd2, 12'h404));
      logStore(DataBase + 32'h404, {2{ValA[15:0]}}, 4'b0011);
      emit(encS(3'd1, 5'd1, 5'd2, 12'h406));
      logStore(DataBase + 32'h406, {2{ValA[15:0]}}, 4'b1100);
      emit(encI(rvCorePkg::OpLoad, 3'd2, 5'd7, 5'd1, 12'h400));   // Read back and store again
      storeWord(5'd7, {4{ValA[7:0]}});
      emit(encI(rvCorePkg::OpLoad, 3'd2, 5'd7, 5'd1, 12'h404));
      storeWord(5'd7, {2{ValA[15:0]}});
      // Sub-word loads
      emit(encS(3'd2, 5'd1, 5'd2, 12'h408));
      logStore(DataBase + 32'h408, ValA, 4'hF);
      loadCheck(3'd0, 3, {{24{ValA[31]}}, ValA[31:24]});
      loadCheck(3'd4, 3, {24'b0, ValA[31:24]});
      loadCheck(3'd0, 0, {{24{ValA[7]}}, ValA[7:0]});
      loadCheck(3'd1, 2, {{16{ValA[31]}}, ValA[31:16]});
      loadCheck(3'd5, 2, {16'b0, ValA[31:16]});
      loadCheck(3'd1, 0, {{16{ValA[15]}}, ValA[15:0]});
      // Branches, both outcomes of each kind
      branchCheck(3'd0, 5'd3, ValB, 5'd3, ValB);
      branchCheck(3'd0, 5'd3, ValB, 5'd4, ValC);
      branchCheck(3'd1, 5'd3, ValB, 5'd4, ValC);
      branchCheck(3'd1, 5'd3, ValB, 5'd3, ValB);
      branchCheck(3'd4, 5'd4, ValC, 5'd3, ValB);
      branchCheck(3'd4, 5'd3, ValB, 5'd4, ValC);
      branchCheck(3'd5, 5'd3, ValB, 5'd4, ValC);
      branchCheck(3'd5, 5'd4, ValC, 5'd3, ValB);
      branchCheck(3'd6, 5'd3, ValB, 5'd4, ValC);
      branchCheck(3'd6, 5'd4, ValC, 5'd3, ValB);
      branchCheck(3'd7, 5'd4, ValC, 5'd3, ValB);
      branchCheck(3'd7, 5'd3, ValB, 5'd4, ValC);
      // Jumps with link
      jp = 32'(pcw) * 4;
      emit(encJ(5'd10, 21'd8));
      poisonStore();
      storeWord(5'd10, jp + 4);
      jp = 32'(pcw + 3) * 4;                      // JALR target past the poison
      emit(encI(rvCorePkg::OpAluImm, 3'd0, 5'd12, 5'd0, jp[11:0]));
      jp = 32'(pcw) * 4;
      emit(encI(rvCorePkg::OpJalr, 3'd0, 5'd11, 5'd12, 12'd0));
      poisonStore();
      storeWord(5'd11, jp + 4);
      // Upper immediates
      emit(encU(rvCorePkg::OpLui, 5'd13, 20'hABCDE));
      storeWord(5'd13, 32'hABCD_E000);
      jp = 32'(pcw) * 4;
      emit(encU(rvCorePkg::OpAuipc, 5'd14, 20'h00012));
      storeWord(5'd14, jp + 32'h0001_2000);
      // x0 stays zero, SYSTEM retires as a no-op
      emit(encI(rvCorePkg::OpAluImm, 3'd0, 5'd0, 5'd0, 12'd123));
      emit(encR(3'd0, 1'b0, 5'd0, 5'd2, 5'd3));
      emit(32'h0000_0073);
      storeWord(5'd0, 32'h0);
      emit(encS(3'd2, 5'd1, 5'd3, 12'h7FC));       // Done marker
      emit(encJ(5'd0, 21'd0));                     // Park
   end

   always @(posedge clk) begin : memPort
      int unsigned delay;
      if (req.rstrb) begin
         delay = $urandom % 4;
         rdata <= mem[req.addr[12:2]];
         rCnt  <= delay;
         rbusy <= delay != 0;
      end else if (rCnt != 0) begin
         rCnt  <= rCnt - 1;
         rbusy <= rCnt > 1;
      end
      if (req.wmask != 4'b0) begin
         for (int i = 0; i < 4; i++) begin
            if (req.wmask[i]) mem[req.addr[12:2]][8*i +: 8] <= req.wdata[8*i +: 8];
         end
         delay = $urandom % 4;
         wCnt  <= delay;
         wbusy <= delay != 0;
      end else if (wCnt != 0) begin
         wCnt  <= wCnt - 1;
         wbusy <= wCnt > 1;
      end
   end

endmodule

// ==== src/rvCore.sv ====
`timescale 1ns/1ps

module rvCore (
   input  logic                       clk,
   input  logic                       reset,
   output rvCorePkg::memRequest       memReq,
   input  logic [rvCorePkg::XLen-1:0] memRdata,
   input  logic                       memRbusy,
   input  logic                       memWbusy
);

   rvCorePkg::decodedInstr          dec;
   rvCorePkg::coreState             state;
   logic [rvCorePkg::XLen-1:0]      instr;
   logic [rvCorePkg::XLen-1:0]      rs1Val;
   logic [rvCorePkg::XLen-1:0]      rs2Val;
   logic [rvCorePkg::XLen-1:0]      aluOut;
   logic [rvCorePkg::XLen-1:0]      aluPlus;
   logic [rvCorePkg::XLen-1:0]      rdData;
   logic [rvCorePkg::XLen-1:0]      wdata;
   logic [rvCorePkg::XLen-1:0]      loadData;
   logic [rvCorePkg::AddrWidth-1:0] pc;
   logic [rvCorePkg::AddrWidth-1:0] lsAddr;
   logic [3:0]                      wmask;
   logic                            predicate;
   logic                            rdWrite;
   logic                            readEn;
   logic                            fetching;

   assign fetching = state == rvCorePkg::FetchInstr || state == rvCorePkg::WaitInstr;
   assign readEn   = state == rvCorePkg::WaitInstr && !memRbusy;  // Instruction word valid

   assign memReq = '{
      addr:  {{(rvCorePkg::XLen-rvCorePkg::AddrWidth){1'b0}}, fetching ? pc : lsAddr},
      wdata: wdata,
      wmask: wmask,
      rstrb: state == rvCorePkg::FetchInstr ||
             (state == rvCorePkg::Execute && dec.opClass == rvCorePkg::OpLoad)
   };

   coreControl control_i (
      .clk, .reset, .memRdata, .memRbusy, .memWbusy, .dec, .aluOut, .aluPlus,
      .predicate, .loadData, .instr, .state, .pc, .rdWrite, .rdData
   );

   instrDecoder decoder_i (.instr, .dec);

   // Register ids come straight off the bus, before the latch is loaded
   regFile regs_i (
      .clk, .rs1Id(memRdata[19:15]), .rs2Id(memRdata[24:20]), .readEn,
      .rdWrite, .rdId(dec.rd), .rdData, .rs1Val, .rs2Val
   );

   intAlu alu_i (.dec, .rs1Val, .rs2Val, .aluOut, .aluPlus, .predicate);

   loadStoreUnit lsu_i (
      .state, .dec, .rs1Val, .rs2Val, .memRdata, .lsAddr, .wdata, .wmask, .loadData
   );

endmodule

// ==== src/coreControl.sv ====
`timescale 1ns/1ps

module coreControl (
   input  logic                            clk,
   input  logic                            reset,
   input  logic [rvCorePkg::XLen-1:0]      memRdata,
   input  logic                            memRbusy,
   input  logic                            memWbusy,
   input  rvCorePkg::decodedInstr          dec,
   input  logic [rvCorePkg::XLen-1:0]      aluOut,
   input  logic [rvCorePkg::XLen-1:0]      aluPlus,
   input  logic                            predicate,
   input  logic [rvCorePkg::XLen-1:0]      loadData,
   output logic [rvCorePkg::XLen-1:0]      instr,
   output rvCorePkg::coreState             state,
   output logic [rvCorePkg::AddrWidth-1:0] pc,
   output logic                            rdWrite,
   output logic [rvCorePkg::XLen-1:0]      rdData
);

   logic isLoad;
   logic isStore;
   logic isBranch;
   logic isJal;
   logic isJalr;
   logic isSystem;
   logic memIdle;
   logic takeImm;
   logic [rvCorePkg::AddrWidth-1:0] pcPlus4;
   logic [rvCorePkg::AddrWidth-1:0] pcPlusImm;
   logic [rvCorePkg::AddrWidth-1:0] pcNext;

   assign isLoad   = dec.opClass == rvCorePkg::OpLoad;
   assign isStore  = dec.opClass == rvCorePkg::OpStore;
   assign isBranch = dec.opClass == rvCorePkg::OpBranch;
   assign isJal    = dec.opClass == rvCorePkg::OpJal;
   assign isJalr   = dec.opClass == rvCorePkg::OpJalr;
   assign isSystem = dec.opClass == rvCorePkg::OpSystem;
   assign memIdle  = !memRbusy && !memWbusy;

   assign pcPlus4   = pc + {{(rvCorePkg::AddrWidth-3){1'b0}}, 3'd4};
   assign pcPlusImm = pc + dec.imm[rvCorePkg::AddrWidth-1:0];  // Branch, JAL, AUIPC
   assign takeImm   = isJal || (isBranch && predicate);

   // JALR target forced onto a word boundary, no compressed code here
   assign pcNext = isJalr  ? {aluPlus[rvCorePkg::AddrWidth-1:2], 2'b00} :
                   takeImm ? pcPlusImm : pcPlus4;

   always_comb begin
      case (dec.opClass)
         rvCorePkg::OpLui:   rdData = dec.imm;
         rvCorePkg::OpAuipc: rdData = {{(rvCorePkg::XLen-rvCorePkg::AddrWidth){1'b0}}, pcPlusImm};
         rvCorePkg::OpJal,
         rvCorePkg::OpJalr:  rdData = {{(rvCorePkg::XLen-rvCorePkg::AddrWidth){1'b0}}, pcPlus4};
         rvCorePkg::OpLoad:  rdData = loadData;
         default:            rdData = aluOut;
      endcase
   end

   // Loads write back once the data is on the bus
   assign rdWrite = (state == rvCorePkg::Execute && !(isBranch || isStore || isSystem || isLoad))
                 || (state == rvCorePkg::WaitMem && isLoad && memIdle);

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= rvCorePkg::WaitMem;       // Drain any bus activity first
         pc    <= rvCorePkg::ResetAddr[rvCorePkg::AddrWidth-1:0];
         instr <= rvCorePkg::NopInstr;      // No stray write-back in WaitMem
      end else begin
         case (state)
            rvCorePkg::FetchInstr: state <= rvCorePkg::WaitInstr;
            rvCorePkg::WaitInstr: begin
               if (!memRbusy) begin
                  instr <= memRdata;
                  state <= rvCorePkg::Execute;
               end
            end
            rvCorePkg::Execute: begin
               pc    <= pcNext;
               state <= (isLoad || isStore) ? rvCorePkg::WaitMem : rvCorePkg::FetchInstr;
            end
            default: begin                  // WaitMem
               if (memIdle) state <= rvCorePkg::FetchInstr;
            end
         endcase
      end
   end

   stateLegal: assert property (@(posedge clk) disable iff (!reset)
      !$isunknown(state) && state inside {rvCorePkg::FetchInstr, rvCorePkg::WaitInstr,
                                          rvCorePkg::Execute, rvCorePkg::WaitMem})
      else $error("FSM state outside its encoding");

   pcAligned: assert property (@(posedge clk) disable iff (!reset) pc[1:0] == 2'b00)
      else $error("PC not word aligned: %h", pc);

endmodule

// ==== src/loadStoreUnit.sv ====
`timescale 1ns/1ps

module loadStoreUnit (
   input  rvCorePkg::coreState             state,
   input  rvCorePkg::decodedInstr          dec,
   input  logic [rvCorePkg::XLen-1:0]      rs1Val,
   input  logic [rvCorePkg::XLen-1:0]      rs2Val,
   input  logic [rvCorePkg::XLen-1:0]      memRdata,
   output logic [rvCorePkg::AddrWidth-1:0] lsAddr,
   output logic [rvCorePkg::XLen-1:0]      wdata,
   output logic [3:0]                      wmask,
   output logic [rvCorePkg::XLen-1:0]      loadData
);

   logic       isByte;
   logic       isHalf;
   logic [3:0] storeMask;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // Immediate is already I or S as the class requires
   assign lsAddr = rs1Val[rvCorePkg::AddrWidth-1:0] + dec.imm[rvCorePkg::AddrWidth-1:0];
   assign isByte = dec.memSize == 2'b00;
   assign isHalf = dec.memSize == 2'b01;

   // Replicate so the addressed lane always sees the low bits of rs2
   assign wdata[7:0]   = rs2Val[7:0];
   assign wdata[15:8]  = lsAddr[0] ? rs2Val[7:0] : rs2Val[15:8];
   assign wdata[23:16] = lsAddr[1] ? rs2Val[7:0] : rs2Val[23:16];
   assign wdata[31:24] = lsAddr[0] ? rs2Val[7:0] :
                         lsAddr[1] ? rs2Val[15:8] : rs2Val[31:24];

   always_comb begin
      if (isByte) begin
         storeMask = 4'b0001 << lsAddr[1:0];          // Single lane
      end else if (isHalf) begin
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

   assign wmask = (state == rvCorePkg::Execute && dec.opClass == rvCorePkg::OpStore)
                  ? storeMask : 4'b0000;

   // Lane select then extend
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !dec.memUnsigned && (isByte ? loadByte[7] : loadHalf[15]);
   assign loadData = isByte ? {{24{loadSign}}, loadByte} :
                     isHalf ? {{16{loadSign}}, loadHalf} : memRdata;

   always_comb begin
      wmaskLegal: assert final (wmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                              4'b0011, 4'b1100, 4'b1111})
         else $error("Illegal store mask %b", wmask);
   end

endmodule

// ==== src/intAlu.sv ====
`timescale 1ns/1ps

module intAlu (
   input  rvCorePkg::decodedInstr     dec,
   input  logic [rvCorePkg::XLen-1:0] rs1Val,
   input  logic [rvCorePkg::XLen-1:0] rs2Val,
   output logic [rvCorePkg::XLen-1:0] aluOut,
   output logic [rvCorePkg::XLen-1:0] aluPlus,    // Also the JALR target
   output logic                       predicate
);

   function automatic logic [rvCorePkg::XLen-1:0] flip(input logic [rvCorePkg::XLen-1:0] x);
      logic [rvCorePkg::XLen-1:0] r;
      for (int i = 0; i < rvCorePkg::XLen; i++) begin
         r[i] = x[rvCorePkg::XLen-1-i];
      end
      return r;
   endfunction

   logic [rvCorePkg::XLen-1:0]        aluIn2;
   logic [rvCorePkg::XLen:0]          aluMinus;   // Carry out is the borrow
   logic                              lt;
   logic                              ltu;
   logic                              eq;
   logic [rvCorePkg::XLen-1:0]        shiftIn;
   logic signed [rvCorePkg::XLen:0]   shiftExt;
   logic signed [rvCorePkg::XLen:0]   shiftFull;
   logic [rvCorePkg::XLen-1:0]        shifted;

   assign aluIn2 = (dec.opClass == rvCorePkg::OpAluReg || dec.opClass == rvCorePkg::OpBranch)
                   ? rs2Val : dec.imm;

   assign aluPlus  = rs1Val + aluIn2;
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1Val} + {{rvCorePkg::XLen{1'b0}}, 1'b1};

   // Signs differ: rs1 is less iff negative
   assign lt  = (rs1Val[rvCorePkg::XLen-1] ^ aluIn2[rvCorePkg::XLen-1])
                ? rs1Val[rvCorePkg::XLen-1] : aluMinus[rvCorePkg::XLen];
   assign ltu = aluMinus[rvCorePkg::XLen];
   assign eq  = aluMinus[rvCorePkg::XLen-1:0] == '0;

   // One arithmetic right shifter, left shifts go through it reversed
   assign shiftIn   = (dec.funct3 == rvCorePkg::Sll) ? flip(rs1Val) : rs1Val;
   assign shiftExt  = {dec.altOp & rs1Val[rvCorePkg::XLen-1], shiftIn};  // Sign fill for SRA
   assign shiftFull = shiftExt >>> aluIn2[4:0];
   assign shifted   = shiftFull[rvCorePkg::XLen-1:0];

   always_comb begin
      case (dec.funct3)
         rvCorePkg::AddSub: aluOut = (dec.altOp && dec.isRegOp) ?
                                     aluMinus[rvCorePkg::XLen-1:0] : aluPlus;
         rvCorePkg::Sll:    aluOut = flip(shifted);
         rvCorePkg::Slt:    aluOut = {{(rvCorePkg::XLen-1){1'b0}}, lt};
         rvCorePkg::Sltu:   aluOut = {{(rvCorePkg::XLen-1){1'b0}}, ltu};
         rvCorePkg::Xor:    aluOut = rs1Val ^ aluIn2;
         rvCorePkg::SrlSra: aluOut = shifted;
         rvCorePkg::Or:     aluOut = rs1Val | aluIn2;
         default:           aluOut = rs1Val & aluIn2;
      endcase
   end

   always_comb begin
      case (dec.funct3)
         rvCorePkg::AddSub: predicate = eq;     // BEQ
         rvCorePkg::Sll:    predicate = !eq;    // BNE
         rvCorePkg::Xor:    predicate = lt;     // BLT
         rvCorePkg::SrlSra: predicate = !lt;    // BGE
         rvCorePkg::Or:     predicate = ltu;    // BLTU
         rvCorePkg::And:    predicate = !ltu;   // BGEU
         default:           predicate = 1'b0;   // Reserved encodings never branch
      endcase
   end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile (
   input  logic                       clk,
   input  logic [4:0]                 rs1Id,
   input  logic [4:0]                 rs2Id,
   input  logic                       readEn,   // WaitInstr with instruction present
   input  logic                       rdWrite,
   input  logic [4:0]                 rdId,
   input  logic [rvCorePkg::XLen-1:0] rdData,
   output logic [rvCorePkg::XLen-1:0] rs1Val,
   output logic [rvCorePkg::XLen-1:0] rs2Val
);

   logic [rvCorePkg::XLen-1:0] regs [rvCorePkg::RegCount];

   always_ff @(posedge clk) begin
      if (rdWrite && rdId != 5'd0) begin   // x0 is hardwired
         regs[rdId] <= rdData;
      end
      if (readEn) begin                    // Operands held until the next decode
         rs1Val <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2Val <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

   x0ReadsZero: assert property (@(posedge clk)
      readEn && (rs1Id == 5'd0 || rs2Id == 5'd0) |=>
         (rs1Val == '0 || $past(rs1Id) != 5'd0) && (rs2Val == '0 || $past(rs2Id) != 5'd0))
      else $error("x0 operand read back nonzero");

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
   input  logic [rvCorePkg::XLen-1:0] instr,
   output rvCorePkg::decodedInstr     dec
);

   logic [rvCorePkg::XLen-1:0] immI;
   logic [rvCorePkg::XLen-1:0] immS;
   logic [rvCorePkg::XLen-1:0] immB;
   logic [rvCorePkg::XLen-1:0] immU;
   logic [rvCorePkg::XLen-1:0] immJ;
   logic [rvCorePkg::XLen-1:0] imm;
   rvCorePkg::opcodeClass      opClass;

   // The five RV32I immediate formats, all sign extended from bit 31
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      case (instr[6:2])
         rvCorePkg::OpLoad:   opClass = rvCorePkg::OpLoad;
         rvCorePkg::OpAluImm: opClass = rvCorePkg::OpAluImm;
         rvCorePkg::OpAuipc:  opClass = rvCorePkg::OpAuipc;
         rvCorePkg::OpStore:  opClass = rvCorePkg::OpStore;
         rvCorePkg::OpAluReg: opClass = rvCorePkg::OpAluReg;
         rvCorePkg::OpLui:    opClass = rvCorePkg::OpLui;
         rvCorePkg::OpBranch: opClass = rvCorePkg::OpBranch;
         rvCorePkg::OpJalr:   opClass = rvCorePkg::OpJalr;
         rvCorePkg::OpJal:    opClass = rvCorePkg::OpJal;
         default:             opClass = rvCorePkg::OpSystem;  // Retires as a no-op
      endcase
   end

   // Only the format of this class goes downstream
   always_comb begin
      case (opClass)
         rvCorePkg::OpStore:                  imm = immS;
         rvCorePkg::OpBranch:                 imm = immB;
         rvCorePkg::OpLui, rvCorePkg::OpAuipc: imm = immU;
         rvCorePkg::OpJal:                    imm = immJ;
         rvCorePkg::OpSystem:                 imm = '0;
         default:                             imm = immI;  // Loads, OP-IMM, JALR
      endcase
   end

   always_comb begin
      dec.opClass     = opClass;
      dec.rd          = instr[11:7];
      dec.funct3      = rvCorePkg::aluFunct'(instr[14:12]);
      dec.altOp       = instr[30];
      dec.isRegOp     = instr[5];
      dec.imm         = imm;
      dec.memSize     = instr[13:12];
      dec.memUnsigned = instr[14];   // funct3[2] of loads
   end

endmodule

// ==== src/rvCorePkg.sv ====
package rvCorePkg;

   localparam int AddrWidth = 24;                       // Significant bus address bits
   localparam logic [31:0] ResetAddr = 32'h0000_0000;   // First fetch after reset
   localparam int XLen = 32;                            // Data word width
   localparam int RegCount = 32;                        // Integer registers x0..x31
   localparam logic [XLen-1:0] NopInstr = 32'h0000_0013; // addi x0, x0, 0

   // Instruction bits 6:2, RV32I major opcodes
   typedef enum logic [4:0] {
      OpLoad   = 5'b00000,
      OpAluImm = 5'b00100,
      OpAuipc  = 5'b00101,
      OpStore  = 5'b01000,
      OpAluReg = 5'b01100,
      OpLui    = 5'b01101,
      OpBranch = 5'b11000,
      OpJalr   = 5'b11001,
      OpJal    = 5'b11011,
      OpSystem = 5'b11100    // Also taken by every unknown opcode
   } opcodeClass;

   typedef enum logic [1:0] {
      FetchInstr = 2'd0,     // Read strobe with PC on the bus
      WaitInstr  = 2'd1,     // Instruction word arrives, operands read
      Execute    = 2'd2,     // PC update and most write-backs
      WaitMem    = 2'd3      // Load/store completion, also the reset state
   } coreState;

   // funct3 of OP and OP-IMM
   // Branches reuse it: AddSub=BEQ Sll=BNE Xor=BLT SrlSra=BGE Or=BLTU And=BGEU
   typedef enum logic [2:0] {
      AddSub = 3'd0,
      Sll    = 3'd1,
      Slt    = 3'd2,
      Sltu   = 3'd3,
      Xor    = 3'd4,
      SrlSra = 3'd5,
      Or     = 3'd6,
      And    = 3'd7
   } aluFunct;

   typedef struct packed {
      opcodeClass      opClass;
      logic [4:0]      rd;
      aluFunct         funct3;
      logic            altOp;        // Bit 30, SUB and SRA
      logic            isRegOp;      // Bit 5, register form of ALU ops
      logic [XLen-1:0] imm;          // Immediate of the instruction's format
      logic [1:0]      memSize;      // 00 byte, 01 halfword, 10 word
      logic            memUnsigned;  // LBU / LHU
   } decodedInstr;

   typedef struct packed {
      logic [XLen-1:0] addr;
      logic [XLen-1:0] wdata;
      logic [3:0]      wmask;        // Byte lanes written this cycle
      logic            rstrb;        // Read start pulse
   } memRequest;

endpackage
